// ==== src/core_defines.svh ====
// widths, depths and reset pc of the integer core slice
// rv32i major opcodes and alu operation codes

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define CORE_XLEN             32
`define CORE_REG_COUNT        32
`define CORE_REG_INDEX_WIDTH  5
`define CORE_FB_DEPTH         4
`define CORE_RESET_PC         32'h0000_0000

`define CORE_OPCODE_OP        7'b0110011
`define CORE_OPCODE_OP_IMM    7'b0010011

`define CORE_ALU_OP_WIDTH     3
`define CORE_ALU_ADD          3'd0
`define CORE_ALU_SUB          3'd1
`define CORE_ALU_AND          3'd2
`define CORE_ALU_OR           3'd3
`define CORE_ALU_XOR          3'd4
`define CORE_ALU_SLL          3'd5
`define CORE_ALU_SRL          3'd6

`endif

// ==== src/core_pkg.sv ====
// instruction word formats and the shared alu result function

`include "core_defines.svh"

package core_pkg;

  typedef struct packed {
    logic [6:0]                         funct7;
    logic [`CORE_REG_INDEX_WIDTH-1:0]   rs2;
    logic [`CORE_REG_INDEX_WIDTH-1:0]   rs1;
    logic [2:0]                         funct3;
    logic [`CORE_REG_INDEX_WIDTH-1:0]   rd;
    logic [6:0]                         opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]                        imm;
    logic [`CORE_REG_INDEX_WIDTH-1:0]   rs1;
    logic [2:0]                         funct3;
    logic [`CORE_REG_INDEX_WIDTH-1:0]   rd;
    logic [6:0]                         opcode;
  } i_type_t;

  // one fetched word, seen as either format
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } inst_t;

  function automatic logic [`CORE_XLEN-1:0] alu_result(
    input logic [`CORE_ALU_OP_WIDTH-1:0] op,
    input logic [`CORE_XLEN-1:0]         a,
    input logic [`CORE_XLEN-1:0]         b
  );
    logic [`CORE_XLEN-1:0] result;
    case (op)
      `CORE_ALU_ADD: result = a + b;
      `CORE_ALU_SUB: result = a - b;
      `CORE_ALU_AND: result = a & b;
      `CORE_ALU_OR:  result = a | b;
      `CORE_ALU_XOR: result = a ^ b;
      // shift amount is the low 5 bits only
      `CORE_ALU_SLL: result = a << b[4:0];
      `CORE_ALU_SRL: result = a >> b[4:0];
      default:       result = '0;
    endcase
    return result;
  endfunction

endpackage

// ==== src/inst_fetch.sv ====
// instruction fetch: program counter and instruction port request control
// each completed transfer becomes one fetch buffer push

`timescale 1ns/1ps

`include "core_defines.svh"

module inst_fetch (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   imem_valid,
  input  logic [`CORE_XLEN-1:0]  imem_data,
  input  logic                   fb_full,
  output logic                   imem_req,
  output logic [`CORE_XLEN-1:0]  imem_addr,
  output logic                   push,
  output core_pkg::inst_t        push_inst,
  output logic [`CORE_XLEN-1:0]  push_pc
);

  logic [`CORE_XLEN-1:0] pc;
  logic                  done;

  assign done = imem_req && imem_valid;

  // one transfer in flight at most, so a free entry now is still free at push
  always_ff @(posedge clock) begin
    if (reset) begin
      pc       <= `CORE_RESET_PC;
      imem_req <= 1'b0;
    end else if (done) begin
      pc       <= pc + 32'd4;
      imem_req <= 1'b0;
    end else if (!imem_req && !fb_full) begin
      imem_req <= 1'b1;
    end
  end

  assign imem_addr = pc;
  assign push      = done;
  assign push_inst = imem_data;
  assign push_pc   = pc;

  // request and address hold until the memory answers
  req_hold_a: assert property (
    @(posedge clock) disable iff (reset)
    imem_req && !imem_valid |=> imem_req && $stable(imem_addr)
  );

endmodule

// ==== src/fetch_buffer.sv ====
// fetch buffer: circular fifo of fetched words and their pcs

`timescale 1ns/1ps

`include "core_defines.svh"

module fetch_buffer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   push,
  input  core_pkg::inst_t        push_inst,
  input  logic [`CORE_XLEN-1:0]  push_pc,
  input  logic                   pop,
  output logic                   head_valid,
  output core_pkg::inst_t        head_inst,
  output logic [`CORE_XLEN-1:0]  head_pc,
  output logic                   full
);

  import core_pkg::*;

  localparam int unsigned DEPTH = `CORE_FB_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  inst_t                 inst_mem [DEPTH];
  logic [`CORE_XLEN-1:0] pc_mem   [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W:0]        count;

  always_ff @(posedge clock) begin
    if (push) begin
      inst_mem[wr_ptr] <= push_inst;
      pc_mem[wr_ptr]   <= push_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

  assign head_valid = (count != '0);
  assign head_inst  = inst_mem[rd_ptr];
  assign head_pc    = pc_mem[rd_ptr];
  assign full       = (count == (PTR_W + 1)'(DEPTH));

  no_overflow_a: assert property (@(posedge clock) disable iff (reset) push |-> !full);
  no_underflow_a: assert property (@(posedge clock) disable iff (reset) pop |-> head_valid);

endmodule

// ==== src/decode_issue.sv ====
// decode of the buffer head and in-order issue to the alu pipe
// holds the head while a source register is busy

`timescale 1ns/1ps

`include "core_defines.svh"

module decode_issue (
  input  logic                              head_valid,
  input  core_pkg::inst_t                   head_inst,
  input  logic [`CORE_XLEN-1:0]             head_pc,
  input  logic                              rs1_busy,
  input  logic                              rs2_busy,
  input  logic [`CORE_XLEN-1:0]             rs1_data,
  input  logic [`CORE_XLEN-1:0]             rs2_data,
  output logic                              pop,
  output logic [`CORE_REG_INDEX_WIDTH-1:0]  rs1_index,
  output logic [`CORE_REG_INDEX_WIDTH-1:0]  rs2_index,
  output logic                              set_busy,
  output logic [`CORE_REG_INDEX_WIDTH-1:0]  set_index,
  output logic                              issue_valid,
  output logic [`CORE_ALU_OP_WIDTH-1:0]     issue_op,
  output logic [`CORE_REG_INDEX_WIDTH-1:0]  issue_rd,
  output logic                              issue_write,
  output logic [`CORE_XLEN-1:0]             issue_pc,
  output logic [`CORE_XLEN-1:0]             issue_a,
  output logic [`CORE_XLEN-1:0]             issue_b
);

  logic [`CORE_ALU_OP_WIDTH-1:0]    op;
  logic [`CORE_REG_INDEX_WIDTH-1:0] rd;
  logic [`CORE_XLEN-1:0]            imm_ext;
  logic                             supported;
  logic                             is_imm;
  logic                             src_busy;

  always_comb begin
    op        = `CORE_ALU_ADD;
    rd        = head_inst.r.rd;
    supported = 1'b0;
    is_imm    = 1'b0;
    case (head_inst.r.opcode)
      `CORE_OPCODE_OP: begin
        supported = 1'b1;
        case (head_inst.r.funct3)
          3'b000: op = head_inst.r.funct7[5] ? `CORE_ALU_SUB : `CORE_ALU_ADD;
          3'b001: op = `CORE_ALU_SLL;
          3'b100: op = `CORE_ALU_XOR;
          3'b101: op = `CORE_ALU_SRL;
          3'b110: op = `CORE_ALU_OR;
          3'b111: op = `CORE_ALU_AND;
          default: supported = 1'b0;
        endcase
        // sra and slt fall to no-op since only sub has a nonzero funct7
        if (head_inst.r.funct7 != 7'b0000000 &&
            !(head_inst.r.funct3 == 3'b000 && head_inst.r.funct7 == 7'b0100000)) begin
          supported = 1'b0;
        end
      end
      `CORE_OPCODE_OP_IMM: begin
        supported = 1'b1;
        is_imm    = 1'b1;
        case (head_inst.i.funct3)
          3'b000: op = `CORE_ALU_ADD;
          3'b100: op = `CORE_ALU_XOR;
          3'b110: op = `CORE_ALU_OR;
          3'b111: op = `CORE_ALU_AND;
          default: supported = 1'b0;
        endcase
      end
      default: supported = 1'b0;
    endcase
  end

  assign imm_ext   = {{(`CORE_XLEN - 12){head_inst.i.imm[11]}}, head_inst.i.imm};
  assign rs1_index = head_inst.r.rs1;
  assign rs2_index = head_inst.r.rs2;

  // no-ops read nothing and never wait
  assign src_busy = supported && (rs1_busy || (!is_imm && rs2_busy));
  assign pop      = head_valid && !src_busy;

  assign issue_valid = pop && supported;
  assign issue_write = (rd != '0);
  assign set_busy    = issue_valid && issue_write;
  assign set_index   = rd;
  assign issue_op    = op;
  assign issue_rd    = rd;
  assign issue_pc    = head_pc;
  assign issue_a     = rs1_data;
  assign issue_b     = is_imm ? imm_ext : rs2_data;

endmodule

// ==== src/scoreboard.sv ====
// busy bit per architectural register
// set at issue, cleared at writeback; x0 never busy

`timescale 1ns/1ps

`include "core_defines.svh"

module scoreboard (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              set_busy,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  set_index,
  input  logic                              clear_busy,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  clear_index,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  rs1_index,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  rs2_index,
  output logic                              rs1_busy,
  output logic                              rs2_busy
);

  logic [`CORE_REG_COUNT-1:0] busy;

  // a set in the same cycle as a clear of that register wins
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (clear_busy) begin
        busy[clear_index] <= 1'b0;
      end
      if (set_busy && set_index != '0) begin
        busy[set_index] <= 1'b1;
      end
    end
  end

  // the writeback in this cycle already frees its register
  assign rs1_busy = busy[rs1_index] && !(clear_busy && clear_index == rs1_index);
  assign rs2_busy = busy[rs2_index] && !(clear_busy && clear_index == rs2_index);

  set_free_a: assert property (
    @(posedge clock) disable iff (reset)
    set_busy && set_index != '0 |-> !busy[set_index] || (clear_busy && clear_index == set_index)
  );

endmodule

// ==== src/regfile.sv ====
// 32 x 32 integer register file
// two combinational read ports with write-through, x0 reads zero

`timescale 1ns/1ps

`include "core_defines.svh"

module regfile (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  rs1_index,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  rs2_index,
  input  logic                              write,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  write_index,
  input  logic [`CORE_XLEN-1:0]             write_data,
  output logic [`CORE_XLEN-1:0]             rs1_data,
  output logic [`CORE_XLEN-1:0]             rs2_data
);

  logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write && write_index != '0) begin
      regs[write_index] <= write_data;
    end
  end

  assign rs1_data = (rs1_index == '0) ? '0 :
                    (write && write_index == rs1_index) ? write_data : regs[rs1_index];
  assign rs2_data = (rs2_index == '0) ? '0 :
                    (write && write_index == rs2_index) ? write_data : regs[rs2_index];

endmodule

// ==== src/alu_pipe.sv ====
// two-stage alu execute pipe
// operand register, then result register driving writeback

`timescale 1ns/1ps

`include "core_defines.svh"

module alu_pipe (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              issue_valid,
  input  logic [`CORE_ALU_OP_WIDTH-1:0]     issue_op,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0]  issue_rd,
  input  logic                              issue_write,
  input  logic [`CORE_XLEN-1:0]             issue_pc,
  input  logic [`CORE_XLEN-1:0]             issue_a,
  input  logic [`CORE_XLEN-1:0]             issue_b,
  output logic                              wb_valid,
  output logic [`CORE_XLEN-1:0]             wb_pc,
  output logic [`CORE_REG_INDEX_WIDTH-1:0]  wb_rd,
  output logic [`CORE_XLEN-1:0]             wb_data
);

  import core_pkg::*;

  logic                             ex_valid;
  logic                             ex_write;
  logic [`CORE_ALU_OP_WIDTH-1:0]    ex_op;
  logic [`CORE_REG_INDEX_WIDTH-1:0] ex_rd;
  logic [`CORE_XLEN-1:0]            ex_pc;
  logic [`CORE_XLEN-1:0]            ex_a;
  logic [`CORE_XLEN-1:0]            ex_b;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
      // x0 writes travel the pipe but never show at writeback
      wb_valid <= ex_valid && ex_write;
    end
  end

  always_ff @(posedge clock) begin
    ex_write <= issue_write;
    ex_op    <= issue_op;
    ex_rd    <= issue_rd;
    ex_pc    <= issue_pc;
    ex_a     <= issue_a;
    ex_b     <= issue_b;
    wb_pc    <= ex_pc;
    wb_rd    <= ex_rd;
    wb_data  <= alu_result(ex_op, ex_a, ex_b);
  end

endmodule

// ==== src/core.sv ====
// top level of the in-order integer core slice
// fetch, fetch buffer, decode/issue, scoreboard, register file, alu pipe

`timescale 1ns/1ps

`include "core_defines.svh"

module core (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              imem_valid,
  input  logic [`CORE_XLEN-1:0]             imem_data,
  output logic                              imem_req,
  output logic [`CORE_XLEN-1:0]             imem_addr,
  output logic                              wb_valid,
  output logic [`CORE_XLEN-1:0]             wb_pc,
  output logic [`CORE_REG_INDEX_WIDTH-1:0]  wb_rd,
  output logic [`CORE_XLEN-1:0]             wb_data
);

  import core_pkg::*;

  logic                             fb_full;
  logic                             push;
  inst_t                            push_inst;
  logic [`CORE_XLEN-1:0]            push_pc;
  logic                             pop;
  logic                             head_valid;
  inst_t                            head_inst;
  logic [`CORE_XLEN-1:0]            head_pc;
  logic [`CORE_REG_INDEX_WIDTH-1:0] rs1_index;
  logic [`CORE_REG_INDEX_WIDTH-1:0] rs2_index;
  logic                             rs1_busy;
  logic                             rs2_busy;
  logic [`CORE_XLEN-1:0]            rs1_data;
  logic [`CORE_XLEN-1:0]            rs2_data;
  logic                             set_busy;
  logic [`CORE_REG_INDEX_WIDTH-1:0] set_index;
  logic                             issue_valid;
  logic [`CORE_ALU_OP_WIDTH-1:0]    issue_op;
  logic [`CORE_REG_INDEX_WIDTH-1:0] issue_rd;
  logic                             issue_write;
  logic [`CORE_XLEN-1:0]            issue_pc;
  logic [`CORE_XLEN-1:0]            issue_a;
  logic [`CORE_XLEN-1:0]            issue_b;

  inst_fetch fetch_inst (
    .clock      (clock),
    .reset      (reset),
    .imem_valid (imem_valid),
    .imem_data  (imem_data),
    .fb_full    (fb_full),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .push       (push),
    .push_inst  (push_inst),
    .push_pc    (push_pc)
  );

  fetch_buffer fb_inst (
    .clock      (clock),
    .reset      (reset),
    .push       (push),
    .push_inst  (push_inst),
    .push_pc    (push_pc),
    .pop        (pop),
    .head_valid (head_valid),
    .head_inst  (head_inst),
    .head_pc    (head_pc),
    .full       (fb_full)
  );

  decode_issue issue_inst (
    .head_valid  (head_valid),
    .head_inst   (head_inst),
    .head_pc     (head_pc),
    .rs1_busy    (rs1_busy),
    .rs2_busy    (rs2_busy),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .pop         (pop),
    .rs1_index   (rs1_index),
    .rs2_index   (rs2_index),
    .set_busy    (set_busy),
    .set_index   (set_index),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_rd    (issue_rd),
    .issue_write (issue_write),
    .issue_pc    (issue_pc),
    .issue_a     (issue_a),
    .issue_b     (issue_b)
  );

  // writeback frees the busy bit and writes the register in the same cycle
  scoreboard sb_inst (
    .clock       (clock),
    .reset       (reset),
    .set_busy    (set_busy),
    .set_index   (set_index),
    .clear_busy  (wb_valid),
    .clear_index (wb_rd),
    .rs1_index   (rs1_index),
    .rs2_index   (rs2_index),
    .rs1_busy    (rs1_busy),
    .rs2_busy    (rs2_busy)
  );

  regfile rf_inst (
    .clock       (clock),
    .reset       (reset),
    .rs1_index   (rs1_index),
    .rs2_index   (rs2_index),
    .write       (wb_valid),
    .write_index (wb_rd),
    .write_data  (wb_data),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data)
  );

  alu_pipe alu_inst (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_rd    (issue_rd),
    .issue_write (issue_write),
    .issue_pc    (issue_pc),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .wb_valid    (wb_valid),
    .wb_pc       (wb_pc),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

endmodule

// ==== verif/tb_core.sv ====
// testbench for the integer core slice
// instruction memory model with lfsr latency, in-order reference model,
// concurrent checks on the fetch port and the writeback trace

`timescale 1ns/1ps

`include "core_defines.svh"

module tb_core;

  import core_pkg::*;

  localparam int PROG_MAX       = 64;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  logic                             clock      = 1'b0;
  logic                             reset      = 1'b1;
  logic                             imem_valid = 1'b0;
  logic [`CORE_XLEN-1:0]            imem_data  = '0;
  logic                             imem_req;
  logic [`CORE_XLEN-1:0]            imem_addr;
  logic                             wb_valid;
  logic [`CORE_XLEN-1:0]            wb_pc;
  logic [`CORE_REG_INDEX_WIDTH-1:0] wb_rd;
  logic [`CORE_XLEN-1:0]            wb_data;

  logic [31:0] prog_mem [PROG_MAX];
  int          prog_len;
  logic [31:0] model_regs [`CORE_REG_COUNT];
  logic [31:0] exp_pc_mem [PROG_MAX];
  logic [4:0]  exp_rd_mem [PROG_MAX];
  logic [31:0] exp_data_mem [PROG_MAX];
  int          exp_count;
  int          retire_index;

  logic        done_seen;
  logic        wb_seen;
  logic [31:0] last_done_addr;
  logic [31:0] last_wb_pc;
  bit          random_latency;
  logic [31:0] lfsr_state = 32'h8c814f40;
  logic        serving;
  logic [1:0]  countdown;

  string test_name = "startup";
  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    tests_failed;

  core core_inst (
    .clock      (clock),
    .reset      (reset),
    .imem_valid (imem_valid),
    .imem_data  (imem_data),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .wb_valid   (wb_valid),
    .wb_pc      (wb_pc),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  always #5 clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if ((addr >> 2) < 32'(prog_len)) begin
      return prog_mem[addr[7:2]];
    end
    return NOP_WORD;
  endfunction

  // answers each request after 0 to 3 extra cycles
  always @(posedge clock) begin : imem_model
    logic [31:0] s;
    logic [1:0]  delay;
    delay = 2'd0;
    if (reset) begin
      imem_valid <= 1'b0;
      serving    <= 1'b0;
      countdown  <= 2'd0;
    end else if (imem_valid) begin
      imem_valid <= 1'b0;
    end else if (imem_req && !serving) begin
      if (random_latency) begin
        s          = lfsr_state;
        delay[0]   = s[0];
        s          = lfsr_step(s);
        delay[1]   = s[0];
        lfsr_state = lfsr_step(s);
      end
      if (delay == 2'd0) begin
        imem_valid <= 1'b1;
        imem_data  <= fetch_word(imem_addr);
      end else begin
        serving   <= 1'b1;
        countdown <= delay - 2'd1;
      end
    end else if (serving) begin
      if (countdown == 2'd0) begin
        imem_valid <= 1'b1;
        imem_data  <= fetch_word(imem_addr);
        serving    <= 1'b0;
      end else begin
        countdown <= countdown - 2'd1;
      end
    end
  end

  // progress of the fetch port and the trace
  always @(posedge clock) begin
    if (reset) begin
      retire_index   <= 0;
      done_seen      <= 1'b0;
      wb_seen        <= 1'b0;
      last_done_addr <= '0;
      last_wb_pc     <= '0;
    end else begin
      if (imem_req && imem_valid) begin
        done_seen      <= 1'b1;
        last_done_addr <= imem_addr;
      end
      if (wb_valid) begin
        retire_index <= retire_index + 1;
        wb_seen      <= 1'b1;
        last_wb_pc   <= wb_pc;
      end
    end
  end

  quiet_after_reset_a: assert property (@(posedge clock) reset |=> !imem_req && !wb_valid)
    else begin
      $display("** Error %s: imem_req,wb_valid expected 0,0 actual %b,%b",
               test_name, $sampled(imem_req), $sampled(wb_valid));
      errors++;
    end

  first_addr_a: assert property (@(posedge clock) disable iff (reset)
    imem_req && !done_seen |-> imem_addr == `CORE_RESET_PC)
    else begin
      $display("** Error %s: imem_addr expected %h actual %h",
               test_name, `CORE_RESET_PC, $sampled(imem_addr));
      errors++;
    end

  next_addr_a: assert property (@(posedge clock) disable iff (reset)
    imem_req && done_seen |-> imem_addr == last_done_addr + 32'd4)
    else begin
      $display("** Error %s: imem_addr expected %h actual %h",
               test_name, $sampled(last_done_addr) + 32'd4, $sampled(imem_addr));
      errors++;
    end

  extra_wb_a: assert property (@(posedge clock) disable iff (reset)
    wb_valid |-> retire_index < exp_count)
    else begin
      $display("%s: writeback from pc %h to x%0d with no write left in the model",
               test_name, $sampled(wb_pc), $sampled(wb_rd));
      errors++;
    end

  wb_pc_a: assert property (@(posedge clock) disable iff (reset)
    wb_valid && retire_index < exp_count |-> wb_pc == exp_pc_mem[retire_index])
    else begin
      $display("** Error %s: wb_pc expected %h actual %h",
               test_name, exp_pc_mem[$sampled(retire_index)], $sampled(wb_pc));
      errors++;
    end

  wb_rd_a: assert property (@(posedge clock) disable iff (reset)
    wb_valid && retire_index < exp_count |-> wb_rd == exp_rd_mem[retire_index])
    else begin
      $display("** Error %s: wb_rd expected %0d actual %0d",
               test_name, exp_rd_mem[$sampled(retire_index)], $sampled(wb_rd));
      errors++;
    end

  wb_data_a: assert property (@(posedge clock) disable iff (reset)
    wb_valid && retire_index < exp_count |-> wb_data == exp_data_mem[retire_index])
    else begin
      $display("** Error %s: wb_data expected %h actual %h",
               test_name, exp_data_mem[$sampled(retire_index)], $sampled(wb_data));
      errors++;
    end

  // program order shows as rising pcs
  wb_order_a: assert property (@(posedge clock) disable iff (reset)
    wb_valid && wb_seen |-> wb_pc > last_wb_pc)
    else begin
      $display("** Error %s: wb_pc expected above %h actual %h",
               test_name, $sampled(last_wb_pc), $sampled(wb_pc));
      errors++;
    end

  // rv32i funct3 for each alu operation
  function automatic logic [2:0] funct3_of(input logic [`CORE_ALU_OP_WIDTH-1:0] op);
    case (op)
      `CORE_ALU_SLL: return 3'b001;
      `CORE_ALU_XOR: return 3'b100;
      `CORE_ALU_SRL: return 3'b101;
      `CORE_ALU_OR:  return 3'b110;
      `CORE_ALU_AND: return 3'b111;
      default:       return 3'b000;
    endcase
  endfunction

  function automatic logic [`CORE_ALU_OP_WIDTH-1:0] op_at(input int n);
    case (n % 7)
      0:       return `CORE_ALU_ADD;
      1:       return `CORE_ALU_SUB;
      2:       return `CORE_ALU_AND;
      3:       return `CORE_ALU_OR;
      4:       return `CORE_ALU_XOR;
      5:       return `CORE_ALU_SLL;
      default: return `CORE_ALU_SRL;
    endcase
  endfunction

  task automatic place_word(input logic [31:0] word);
    prog_mem[prog_len] = word;
    prog_len++;
  endtask

  task automatic record_write(input logic [4:0] rd, input logic [31:0] pc,
                              input logic [31:0] value);
    if (rd != 5'd0) begin
      model_regs[rd]          = value;
      exp_pc_mem[exp_count]   = pc;
      exp_rd_mem[exp_count]   = rd;
      exp_data_mem[exp_count] = value;
      exp_count++;
    end
  endtask

  task automatic emit_r(input logic [`CORE_ALU_OP_WIDTH-1:0] op,
                        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] pc;
    logic [6:0]  funct7;
    pc     = 32'(prog_len) * 32'd4 + `CORE_RESET_PC;
    funct7 = (op == `CORE_ALU_SUB) ? 7'b0100000 : 7'b0000000;
    place_word({funct7, rs2, rs1, funct3_of(op), rd, `CORE_OPCODE_OP});
    record_write(rd, pc, alu_result(op, model_regs[rs1], model_regs[rs2]));
  endtask

  task automatic emit_i(input logic [`CORE_ALU_OP_WIDTH-1:0] op,
                        input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] pc;
    pc = 32'(prog_len) * 32'd4 + `CORE_RESET_PC;
    place_word({imm, rs1, funct3_of(op), rd, `CORE_OPCODE_OP_IMM});
    record_write(rd, pc, alu_result(op, model_regs[rs1], {{20{imm[11]}}, imm}));
  endtask

  // holds the core in reset while the next program is built
  task automatic start_test(input string name, input bit random);
    @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    test_name       = name;
    random_latency  = random;
    errors_at_start = errors;
    prog_len        = 0;
    exp_count       = 0;
    for (int r = 0; r < `CORE_REG_COUNT; r++) begin
      model_regs[r] = '0;
    end
  endtask

  task automatic finish_test();
    int cycles;
    cycles = 0;
    @(posedge clock);
    reset <= 1'b0;
    while (retire_index != exp_count && cycles < TIMEOUT_CYCLES) begin
      @(negedge clock);
      cycles++;
    end
    if (retire_index != exp_count) begin
      $display("%s: timed out after %0d cycles with %0d of %0d writebacks seen",
               test_name, cycles, retire_index, exp_count);
      errors++;
    end
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %-16s passed, %0d writebacks", test_name, exp_count);
    end else begin
      tests_failed++;
      $display("test %-16s failed, %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  initial begin
    start_test("reset_fetch", 1'b1);
    emit_i(`CORE_ALU_ADD, 5'd1, 5'd0, 12'd5);
    emit_i(`CORE_ALU_ADD, 5'd2, 5'd1, -12'sd3);
    emit_i(`CORE_ALU_XOR, 5'd3, 5'd2, 12'h7ff);
    finish_test();

    start_test("independent_alu", 1'b0);
    emit_i(`CORE_ALU_ADD, 5'd1, 5'd0, 12'h5a5);
    emit_i(`CORE_ALU_ADD, 5'd2, 5'd0, 12'haac);
    emit_i(`CORE_ALU_ADD, 5'd3, 5'd0, 12'd7);
    emit_i(`CORE_ALU_ADD, 5'd4, 5'd0, 12'h3e4);
    emit_r(`CORE_ALU_ADD, 5'd10, 5'd1, 5'd2);
    emit_r(`CORE_ALU_SUB, 5'd11, 5'd1, 5'd2);
    emit_r(`CORE_ALU_AND, 5'd12, 5'd1, 5'd2);
    emit_r(`CORE_ALU_OR,  5'd13, 5'd1, 5'd2);
    emit_r(`CORE_ALU_XOR, 5'd14, 5'd1, 5'd2);
    emit_r(`CORE_ALU_SLL, 5'd15, 5'd1, 5'd3);
    emit_r(`CORE_ALU_SRL, 5'd16, 5'd2, 5'd4);
    emit_i(`CORE_ALU_ADD, 5'd17, 5'd1, -12'sd100);
    emit_i(`CORE_ALU_AND, 5'd18, 5'd2, 12'h0f0);
    emit_i(`CORE_ALU_OR,  5'd19, 5'd1, 12'h700);
    emit_i(`CORE_ALU_XOR, 5'd20, 5'd2, 12'hfff);
    finish_test();

    start_test("raw_chains", 1'b0);
    emit_i(`CORE_ALU_ADD, 5'd5, 5'd0, 12'd3);
    emit_r(`CORE_ALU_ADD, 5'd5, 5'd5, 5'd5);
    emit_i(`CORE_ALU_ADD, 5'd6, 5'd5, -12'sd1);
    emit_r(`CORE_ALU_SLL, 5'd7, 5'd5, 5'd6);
    emit_r(`CORE_ALU_SUB, 5'd8, 5'd6, 5'd7);
    emit_r(`CORE_ALU_SRL, 5'd9, 5'd8, 5'd6);
    emit_r(`CORE_ALU_XOR, 5'd10, 5'd9, 5'd8);
    emit_r(`CORE_ALU_AND, 5'd11, 5'd10, 5'd9);
    emit_r(`CORE_ALU_OR,  5'd12, 5'd11, 5'd10);
    emit_i(`CORE_ALU_OR,  5'd12, 5'd12, 12'h100);
    emit_i(`CORE_ALU_AND, 5'd13, 5'd12, 12'hff0);
    emit_r(`CORE_ALU_ADD, 5'd14, 5'd0, 5'd13);
    finish_test();

    start_test("random_latency", 1'b1);
    for (int k = 1; k <= 6; k++) begin
      emit_i(`CORE_ALU_ADD, 5'(k), 5'd0, 12'(k * 291 - 700));
    end
    // mixed dependencies across x1..x6
    for (int k = 0; k < 24; k++) begin
      if (k % 2 == 0) begin
        emit_r(op_at(k / 2), 5'(1 + k % 6), 5'(1 + (k + 2) % 6), 5'(1 + (k + 4) % 6));
      end else begin
        emit_i(op_at((k / 2) % 5 == 1 ? 0 : (k / 2) % 5), 5'(1 + k % 6),
               5'(1 + (k + 3) % 6), 12'(k * 37 - 200));
      end
    end
    finish_test();

    start_test("no_writeback", 1'b1);
    emit_i(`CORE_ALU_ADD, 5'd1, 5'd0, 12'd9);
    emit_r(`CORE_ALU_ADD, 5'd0, 5'd1, 5'd1);
    place_word(32'h0000_0073);
    place_word(32'h4020_d0b3);
    place_word(32'h0020_9093);
    place_word(32'h0020_a0b3);
    emit_i(`CORE_ALU_ADD, 5'd0, 5'd1, 12'd5);
    emit_r(`CORE_ALU_ADD, 5'd2, 5'd0, 5'd1);
    emit_i(`CORE_ALU_OR,  5'd3, 5'd0, 12'd0);
    emit_r(`CORE_ALU_ADD, 5'd4, 5'd0, 5'd0);
    emit_r(`CORE_ALU_ADD, 5'd5, 5'd1, 5'd2);
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+src
src/core_pkg.sv
src/inst_fetch.sv
src/fetch_buffer.sv
src/decode_issue.sv
src/scoreboard.sv
src/regfile.sv
src/alu_pipe.sv
src/core.sv
verif/tb_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f tb.f -o tb_core_sim \
  && ./obj_dir/tb_core_sim 2>&1 | tee sim.log \
  && ! grep -q "Finished with errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
